// ==== Bender.yml ====
package:
  name: biu_ahb

sources:
  - biu_ahb_pkg.sv
  - biu2ahb.sv
  - ahb_sram_slave.sv
  - biu_ahb_top.sv
  - target: any(simulation, test)
    files:
      - tb_clkgen.sv
      - tb_biu_ahb.sv

// ==== ahb_sram_slave.sv ====
`timescale 1ns/1ps

module ahb_sram_slave
  import biu_ahb_pkg::*;
#(
  parameter int XLEN        = 64,
  parameter int PLEN        = 32,
  parameter int MEM_BYTES   = 4096,
  parameter int WAIT_STATES = 1
) (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            hsel_i,
  input  logic [PLEN-1:0] haddr_i,
  input  logic [XLEN-1:0] hwdata_i,
  input  logic            hwrite_i,
  input  logic [2:0]      hsize_i,
  input  logic [1:0]      htrans_i,
  output logic [XLEN-1:0] hrdata_o,
  output logic            hready_o,
  output logic            hresp_o
);

  localparam int BYTES  = XLEN / 8;
  localparam int DEPTH  = MEM_BYTES / BYTES;
  localparam int OFFS_W = $clog2(BYTES);
  localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int WCNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [XLEN-1:0]   mem [DEPTH];

  logic              addr_phase;  // valid transfer on the address bus
  logic              dp_valid;    // data phase in progress
  logic              dp_err;      // that data phase is out of range
  logic              err_tail;    // second error cycle
  logic [WCNT_W-1:0] wait_cnt;
  logic [PLEN-1:0]   dp_addr;
  logic              dp_write;
  logic [2:0]        dp_size;
  logic [IDX_W-1:0]  dp_idx;
  logic [7:0]        dp_lanes;
  logic              beat_done;   // okay data phase ends this cycle

  assign addr_phase = hsel_i & ((htrans_i == HTRANS_NONSEQ) | (htrans_i == HTRANS_SEQ));

  assign dp_idx   = dp_addr[OFFS_W +: IDX_W];
  assign dp_lanes = byte_lanes(dp_size, dp_addr[2:0], BYTES);

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_comb begin
    hready_o = 1'b1;
    hresp_o  = HRESP_OKAY;
    if (dp_valid) begin
      if (dp_err) begin
        hready_o = err_tail;  // low first, then high, error both cycles
        hresp_o  = HRESP_ERROR;
      end else begin
        hready_o = (wait_cnt == '0);
      end
    end
  end

  assign beat_done = dp_valid & ~dp_err & hready_o;

  // data phase control
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid <= 1'b0;
      dp_err   <= 1'b0;
      err_tail <= 1'b0;
      wait_cnt <= '0;
    end else if (hready_o) begin
      // previous phase done, take the next address phase
      dp_valid <= addr_phase;
      dp_err   <= addr_phase & (haddr_i >= PLEN'(MEM_BYTES));
      err_tail <= 1'b0;
      wait_cnt <= WCNT_W'(WAIT_STATES);
    end else if (dp_err) begin
      err_tail <= 1'b1;
    end else begin
      wait_cnt <= wait_cnt - 1'b1;  // count down wait states
    end
  end

  // address phase payload
  always_ff @(posedge HCLK) begin
    if (hready_o && addr_phase) begin
      dp_addr  <= haddr_i;
      dp_write <= hwrite_i;
      dp_size  <= hsize_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // only the addressed byte lanes change
  always_ff @(posedge HCLK) begin
    if (beat_done && dp_write) begin
      for (int b = 0; b < BYTES; b++) begin
        if (dp_lanes[b]) begin
          mem[dp_idx][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign hrdata_o = mem[dp_idx];  // whole word, sampled with hready

endmodule

// ==== biu2ahb.sv ====
`timescale 1ns/1ps

module biu2ahb
  import biu_ahb_pkg::*;
#(
  parameter int XLEN = 64,
  parameter int PLEN = 32
) (
  input  logic            HCLK,
  input  logic            HRESETn,

  // core side
  input  logic            biu_stb_i,      // request strobe
  output logic            biu_stb_ack_o,  // request taken
  output logic            biu_d_ack_o,    // write data taken, next please
  input  logic [PLEN-1:0] biu_adri_i,
  output logic [PLEN-1:0] biu_adro_o,     // address of the acked beat
  input  logic [2:0]      biu_size_i,
  input  logic [2:0]      biu_type_i,
  input  logic [2:0]      biu_prot_i,
  input  logic            biu_lock_i,
  input  logic            biu_we_i,
  input  logic [XLEN-1:0] biu_d_i,
  output logic [XLEN-1:0] biu_q_o,
  output logic            biu_ack_o,      // one per completed beat
  output logic            biu_err_o,      // one per failed burst

  // ahb-lite master
  output logic            hsel_o,
  output logic [PLEN-1:0] haddr_o,
  output logic [XLEN-1:0] hwdata_o,
  output logic            hwrite_o,
  output logic [2:0]      hsize_o,
  output logic [2:0]      hburst_o,
  output logic [3:0]      hprot_o,
  output logic [1:0]      htrans_o,
  output logic            hmastlock_o,
  input  logic [XLEN-1:0] hrdata_i,
  input  logic            hready_i,
  input  logic            hresp_i
);

  localparam int BYTES = XLEN / 8;

  logic [3:0] burst_cnt;   // beats still to issue after this one
  logic       data_ena;    // live beat in address phase
  logic       data_ena_d;  // live beat in data phase
  logic       err_first;   // first cycle of the error response

  assign err_first = ~hready_i & (hresp_i == HRESP_ERROR);

  ////////////////////////////////////////////////////////////
  // address phase sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt   <= 4'd0;
      data_ena    <= 1'b0;
      biu_err_o   <= 1'b0;
      hsel_o      <= 1'b0;
      haddr_o     <= '0;
      hwrite_o    <= 1'b0;
      hsize_o     <= HSIZE_BYTE;
      hburst_o    <= HBURST_SINGLE;
      hprot_o     <= HPROT_DATA | HPROT_PRIVILEGED | HPROT_NON_BUFFERABLE | HPROT_NON_CACHEABLE;
      htrans_o    <= HTRANS_IDLE;
      hmastlock_o <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // pulse

      if (hready_i) begin
        if (burst_cnt == 4'd0) begin
          // new request, held back for one cycle after an error
          if (biu_stb_i && !biu_err_o) begin
            burst_cnt   <= burst_beats(biu_type_i);
            data_ena    <= 1'b1;
            hsel_o      <= 1'b1;
            htrans_o    <= HTRANS_NONSEQ;
            haddr_o     <= biu_adri_i;
            hwrite_o    <= biu_we_i;
            hsize_o     <= biu_size2hsize(biu_size_i);
            hburst_o    <= biu_type2hburst(biu_type_i);
            hprot_o     <= biu_prot2hprot(biu_prot_i);
            hmastlock_o <= biu_lock_i;
          end else begin
            data_ena    <= 1'b0;
            hsel_o      <= 1'b0;
            htrans_o    <= HTRANS_IDLE;
            hmastlock_o <= biu_lock_i;  // lock may stay up between transfers
          end
        end else begin
          // next beat of the burst
          burst_cnt <= burst_cnt - 4'd1;
          data_ena  <= 1'b1;
          htrans_o  <= HTRANS_SEQ;
          haddr_o   <= PLEN'(next_beat_addr(64'(haddr_o), hburst_o, BYTES));
        end
      end else if (err_first) begin
        // abort, idle before the second error cycle
        burst_cnt <= 4'd0;
        data_ena  <= 1'b0;
        hsel_o    <= 1'b0;
        htrans_o  <= HTRANS_IDLE;
        biu_err_o <= 1'b1;
      end
      // wait state without error holds everything
    end
  end

  ////////////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////////////

  // write data and beat address move one phase behind haddr
  always_ff @(posedge HCLK) begin
    if (hready_i && data_ena) begin
      hwdata_o   <= biu_d_i;
      biu_adro_o <= haddr_o;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (err_first) begin
      data_ena_d <= 1'b0;  // no ack in the second error cycle
    end else if (hready_i) begin
      data_ena_d <= data_ena;
    end
  end

  assign biu_q_o       = hrdata_i;  // valid with biu_ack_o
  assign biu_ack_o     = hready_i & data_ena_d;
  assign biu_d_ack_o   = hready_i & data_ena;
  assign biu_stb_ack_o = hready_i & (burst_cnt == 4'd0) & biu_stb_i & ~biu_err_o;

endmodule

// ==== biu_ahb_pkg.sv ====
package biu_ahb_pkg;

  ////////////////////////////////////////////////////////////
  // ahb-lite codes
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;
  localparam logic [2:0] HSIZE_DWORD = 3'b011;

  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;
  localparam logic [2:0] HBURST_WRAP4  = 3'b010;
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HBURST_WRAP8  = 3'b100;
  localparam logic [2:0] HBURST_INCR8  = 3'b101;
  localparam logic [2:0] HBURST_WRAP16 = 3'b110;
  localparam logic [2:0] HBURST_INCR16 = 3'b111;

  // hprot bit 0 data, bit 1 privileged, bit 2 bufferable, bit 3 cacheable
  localparam logic [3:0] HPROT_OPCODE         = 4'b0000;
  localparam logic [3:0] HPROT_DATA           = 4'b0001;
  localparam logic [3:0] HPROT_USER           = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED     = 4'b0010;
  localparam logic [3:0] HPROT_NON_BUFFERABLE = 4'b0000;
  localparam logic [3:0] HPROT_NON_CACHEABLE  = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE      = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////////////////////////////////////////////
  // core side codes
  ////////////////////////////////////////////////////////////

  localparam logic [2:0] SINGLE = 3'd0;
  localparam logic [2:0] INCR   = 3'd1;  // undefined length, runs as one beat
  localparam logic [2:0] WRAP4  = 3'd2;
  localparam logic [2:0] INCR4  = 3'd3;
  localparam logic [2:0] WRAP8  = 3'd4;
  localparam logic [2:0] INCR8  = 3'd5;
  localparam logic [2:0] WRAP16 = 3'd6;
  localparam logic [2:0] INCR16 = 3'd7;

  localparam logic [2:0] PROT_DATA       = 3'b001;  // clear means opcode fetch
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  ////////////////////////////////////////////////////////////
  // conversions
  ////////////////////////////////////////////////////////////

  // beats minus one
  function automatic logic [3:0] burst_beats(input logic [2:0] biu_type);
    case (biu_type)
      WRAP4, INCR4:   return 4'd3;
      WRAP8, INCR8:   return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default:        return 4'd0;  // single, incr
    endcase
  endfunction

  function automatic logic [2:0] biu_size2hsize(input logic [2:0] size);
    case (size)
      3'd0:    return HSIZE_BYTE;
      3'd1:    return HSIZE_HWORD;
      3'd2:    return HSIZE_WORD;
      default: return HSIZE_DWORD;
    endcase
  endfunction

  function automatic logic [2:0] biu_type2hburst(input logic [2:0] biu_type);
    case (biu_type)
      INCR:    return HBURST_INCR;
      WRAP4:   return HBURST_WRAP4;
      INCR4:   return HBURST_INCR4;
      WRAP8:   return HBURST_WRAP8;
      INCR8:   return HBURST_INCR8;
      WRAP16:  return HBURST_WRAP16;
      INCR16:  return HBURST_INCR16;
      default: return HBURST_SINGLE;
    endcase
  endfunction

  function automatic logic [3:0] biu_prot2hprot(input logic [2:0] prot);
    logic [3:0] hp;
    hp = HPROT_NON_BUFFERABLE;
    hp = hp | (((prot & PROT_DATA) != 3'b0) ? HPROT_DATA : HPROT_OPCODE);
    hp = hp | (((prot & PROT_PRIVILEGED) != 3'b0) ? HPROT_PRIVILEGED : HPROT_USER);
    hp = hp | (((prot & PROT_CACHEABLE) != 3'b0) ? HPROT_CACHEABLE : HPROT_NON_CACHEABLE);
    return hp;
  endfunction

  // next aligned word; wrap bursts keep the bits above beats*bytes
  function automatic logic [63:0] next_beat_addr(input logic [63:0] addr,
                                                 input logic [2:0]  hburst,
                                                 input int unsigned bytes);
    logic [63:0] nxt;
    logic [63:0] wrap_mask;
    nxt = (addr + 64'(bytes)) & ~(64'(bytes) - 64'd1);
    case (hburst)
      HBURST_WRAP4:  wrap_mask = 64'(bytes * 4) - 64'd1;
      HBURST_WRAP8:  wrap_mask = 64'(bytes * 8) - 64'd1;
      HBURST_WRAP16: wrap_mask = 64'(bytes * 16) - 64'd1;
      default:       wrap_mask = '1;  // plain increment
    endcase
    return (addr & ~wrap_mask) | (nxt & wrap_mask);
  endfunction

  // byte lanes hit by one transfer, bus up to 8 bytes wide
  function automatic logic [7:0] byte_lanes(input logic [2:0]  hsize,
                                            input logic [2:0]  offs,
                                            input int unsigned bytes);
    logic [7:0] base;
    logic [2:0] lane;
    case (hsize)
      HSIZE_BYTE: begin
        base = 8'h01;
        lane = offs;
      end
      HSIZE_HWORD: begin
        base = 8'h03;
        lane = {offs[2:1], 1'b0};
      end
      HSIZE_WORD: begin
        base = 8'h0f;
        lane = {offs[2], 2'b00};
      end
      default: begin
        base = 8'hff;
        lane = 3'b000;
      end
    endcase
    lane = lane & 3'(bytes - 1);  // drop offset bits above the bus
    return (base << lane) & 8'((16'd1 << bytes) - 16'd1);
  endfunction

endpackage

// ==== biu_ahb_top.sv ====
`timescale 1ns/1ps

module biu_ahb_top #(
  parameter int XLEN        = 64,
  parameter int PLEN        = 32,
  parameter int MEM_BYTES   = 4096,
  parameter int WAIT_STATES = 1
) (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            biu_stb_i,
  output logic            biu_stb_ack_o,
  output logic            biu_d_ack_o,
  input  logic [PLEN-1:0] biu_adri_i,
  output logic [PLEN-1:0] biu_adro_o,
  input  logic [2:0]      biu_size_i,
  input  logic [2:0]      biu_type_i,
  input  logic [2:0]      biu_prot_i,
  input  logic            biu_lock_i,
  input  logic            biu_we_i,
  input  logic [XLEN-1:0] biu_d_i,
  output logic [XLEN-1:0] biu_q_o,
  output logic            biu_ack_o,
  output logic            biu_err_o
);

  // ahb-lite between bridge and memory
  logic            hsel;
  logic [PLEN-1:0] haddr;
  logic [XLEN-1:0] hwdata;
  logic            hwrite;
  logic [2:0]      hsize;
  logic [1:0]      htrans;
  logic [XLEN-1:0] hrdata;
  logic            hready;
  logic            hresp;

  biu2ahb #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_biu2ahb (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_prot_i    (biu_prot_i),
    .biu_lock_i    (biu_lock_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .hsel_o        (hsel),
    .haddr_o       (haddr),
    .hwdata_o      (hwdata),
    .hwrite_o      (hwrite),
    .hsize_o       (hsize),
    .hburst_o      (),  // memory ignores burst kind
    .hprot_o       (),  // no protection checks
    .htrans_o      (htrans),
    .hmastlock_o   (),  // single master, nothing to lock
    .hrdata_i      (hrdata),
    .hready_i      (hready),
    .hresp_i       (hresp)
  );

  ahb_sram_slave #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_BYTES   (MEM_BYTES),
    .WAIT_STATES (WAIT_STATES)
  ) u_sram (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .hsel_i   (hsel),
    .haddr_i  (haddr),
    .hwdata_i (hwdata),
    .hwrite_i (hwrite),
    .hsize_i  (hsize),
    .htrans_i (htrans),
    .hrdata_o (hrdata),
    .hready_o (hready),
    .hresp_o  (hresp)
  );

endmodule

// ==== tb_biu_ahb.sv ====
`timescale 1ns/1ps

module tb_biu_ahb
  import biu_ahb_pkg::*;
#(
  parameter int XLEN        = 64,
  parameter int PLEN        = 32,
  parameter int MEM_BYTES   = 4096,
  parameter int WAIT_STATES = 1
);

  localparam int         BYTES         = XLEN / 8;
  localparam logic [2:0] SZ_BUS        = 3'($clog2(BYTES));  // full bus width
  localparam int         PLANNED_BEATS = 680;                // upper bound of all tests
  localparam int         CYCLE_LIMIT   = PLANNED_BEATS * (WAIT_STATES + 4) + 16 + 200;

  logic HCLK, HRESETn;
  logic biu_stb_i, biu_stb_ack_o, biu_d_ack_o, biu_lock_i, biu_we_i, biu_ack_o, biu_err_o;
  logic [PLEN-1:0] biu_adri_i, biu_adro_o;
  logic [2:0]      biu_size_i, biu_type_i, biu_prot_i;
  logic [XLEN-1:0] biu_d_i, biu_q_o;

  logic [7:0]      ref_mem [MEM_BYTES];  // byte mirror of the memory
  logic            exp_err[$];           // one entry per ack or error event
  logic [PLEN-1:0] exp_adr[$];
  logic [XLEN-1:0] exp_dat[$];
  logic            exp_rd[$];
  logic [XLEN-1:0] wdq[$];               // write data for each issued beat
  logic            e_err, e_rd;
  logic [PLEN-1:0] e_adr, a;
  logic [XLEN-1:0] e_dat;
  logic [2:0]      sz;
  logic [31:0]     rng = 32'h7336;
  int cycles = 0;

  tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clkgen (.clk_o(HCLK), .rst_n_o(HRESETn));

  biu_ahb_top #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_BYTES   (MEM_BYTES),
    .WAIT_STATES (WAIT_STATES)
  ) dut0 (.*);

  ////////////////////////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    logic [XLEN-1:0] w;
    for (int i = 0; i < XLEN / 32; i++) begin
      rng = xorshift32(rng);
      w[32*i +: 32] = rng;
    end
    return w;
  endfunction

  function automatic logic [PLEN-1:0] rand_addr(input int span, input int align);
    rng = xorshift32(rng);
    return PLEN'((rng % span) & ~(align - 1));
  endfunction

  // queues the expected events of one request and returns 1 on an error
  function automatic logic model_req(input logic [PLEN-1:0] adr, input logic [2:0] size,
                                     input logic [2:0] btype, input logic we);
    logic [63:0]     ad;
    logic [XLEN-1:0] wd, rd;
    logic [2:0]      hb;
    int              base, nb, offs;
    case (btype)
      WRAP4:   hb = HBURST_WRAP4;
      WRAP8:   hb = HBURST_WRAP8;
      WRAP16:  hb = HBURST_WRAP16;
      default: hb = HBURST_INCR;
    endcase
    ad = 64'(adr);
    for (int k = 0; k <= int'(burst_beats(btype)); k++) begin
      wd = we ? rand_word() : '0;
      wdq.push_back(wd);  // beat is taken even when it errors
      if (ad >= 64'(MEM_BYTES)) begin
        exp_err.push_back(1'b1);
        exp_adr.push_back('0);
        exp_dat.push_back('0);
        exp_rd.push_back(1'b0);
        return 1'b1;  // rest of the burst never reaches the bus
      end
      base = int'(ad) & ~(BYTES - 1);
      nb   = 1 << size;
      offs = int'(ad) & (BYTES - 1) & ~(nb - 1);
      if (we) begin
        for (int b = offs; b < offs + nb; b++) ref_mem[base + b] = wd[8*b +: 8];
      end
      for (int b = 0; b < BYTES; b++) rd[8*b +: 8] = ref_mem[base + b];
      exp_err.push_back(1'b0);
      exp_adr.push_back(PLEN'(ad));
      exp_dat.push_back(rd);
      exp_rd.push_back(~we);
      ad = next_beat_addr(ad, hb, BYTES);
    end
    return 1'b0;
  endfunction

  task automatic stop_fail();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_fail();
    end
  endtask

  task automatic check_addr(input string name, input logic [PLEN-1:0] got,
                            input logic [PLEN-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_fail();
    end
  endtask

  task automatic idle();
    @(negedge HCLK);
    biu_stb_i = 1'b0;
  endtask

  task automatic drain();
    idle();
    while (exp_err.size() != 0) @(posedge HCLK);
  endtask

  // strobe stays up straight into the next request
  task automatic issue(input logic [PLEN-1:0] adr, input logic [2:0] size,
                       input logic [2:0] btype, input logic we);
    logic errs;
    @(negedge HCLK);
    errs       = model_req(adr, size, btype, we);
    biu_stb_i  = 1'b1;
    biu_adri_i = adr;
    biu_size_i = size;
    biu_type_i = btype;
    biu_we_i   = we;
    if (wdq.size() != 0) biu_d_i = wdq[0];
    do @(posedge HCLK); while (!biu_stb_ack_o);
    if (errs) drain();  // an abort also drops a request queued behind it
  endtask

  ////////////////////////////////////////////////////////////
  // drivers and checker
  ////////////////////////////////////////////////////////////

  always @(posedge HCLK) if (HRESETn && biu_d_ack_o && wdq.size() != 0) void'(wdq.pop_front());
  always @(negedge HCLK) biu_d_i = (wdq.size() != 0) ? wdq[0] : '0;

  always @(posedge HCLK) begin
    if (HRESETn) begin
      if (biu_ack_o || biu_err_o) begin
        if (exp_err.size() == 0) begin
          $display("response at %0t with no transfer outstanding", $time);
          stop_fail();
        end
        e_err = exp_err.pop_front();
        e_adr = exp_adr.pop_front();
        e_dat = exp_dat.pop_front();
        e_rd  = exp_rd.pop_front();
        if (biu_ack_o && biu_err_o) begin
          $display("ack and error in the same cycle at %0t", $time);
          stop_fail();
        end else if (biu_err_o != e_err) begin
          $display("%s at %0t for beat %h", e_err ? "ack instead of error" : "unexpected error",
                   $time, e_adr);
          stop_fail();
        end else if (biu_ack_o) begin
          check_addr("biu_adro_o", biu_adro_o, e_adr);
          if (e_rd) check_data("biu_q_o", biu_q_o, e_dat);
        end
      end
    end
  end

  always @(posedge HCLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, transfers still outstanding", cycles);
      stop_fail();
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    biu_stb_i  = 1'b0;
    biu_adri_i = '0;
    biu_size_i = 3'd0;
    biu_type_i = SINGLE;
    biu_prot_i = PROT_DATA | PROT_PRIVILEGED;
    biu_lock_i = 1'b0;
    biu_we_i   = 1'b0;
    biu_d_i    = '0;
    wait (HRESETn === 1'b1);
    @(posedge HCLK);
    if (biu_ack_o || biu_err_o || biu_d_ack_o || biu_stb_ack_o) begin
      $display("handshake outputs not quiet after reset");
      stop_fail();
    end
    // fill with incr16 write bursts back to back
    for (int i = 0; i < MEM_BYTES / (16 * BYTES); i++)
      issue(PLEN'(i * 16 * BYTES), SZ_BUS, INCR16, 1'b1);
    for (int i = 0; i < 8; i++) begin  // full word write then read back
      a = rand_addr(MEM_BYTES, BYTES);
      issue(a, SZ_BUS, SINGLE, 1'b1);
      issue(a, SZ_BUS, SINGLE, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin  // byte, halfword and word merges
      rng = xorshift32(rng);
      sz  = 3'(rng % 3);
      a   = rand_addr(MEM_BYTES, 1 << sz);
      issue(a, sz, SINGLE, 1'b1);
      issue(a & ~PLEN'(BYTES - 1), SZ_BUS, SINGLE, 1'b0);
    end
    for (int i = 0; i < 2; i++) begin  // incrementing bursts clear of the top
      a = rand_addr(MEM_BYTES - 16 * BYTES, BYTES);
      issue(a, SZ_BUS, INCR4, 1'b1);
      issue(a, SZ_BUS, INCR4, 1'b0);
      issue(a, SZ_BUS, INCR8, 1'b1);
      issue(a, SZ_BUS, INCR8, 1'b0);
    end
    for (int i = 0; i < 2; i++) begin
      a = rand_addr(MEM_BYTES, BYTES) | PLEN'(BYTES);  // odd beat inside the wrap block
      issue(a, SZ_BUS, WRAP4, 1'b1);
      issue(a, SZ_BUS, WRAP4, 1'b0);
      issue(a, SZ_BUS, WRAP8, 1'b1);
      issue(a, SZ_BUS, WRAP8, 1'b0);
    end
    // out of range write would alias onto word a if it leaked
    a = rand_addr(MEM_BYTES, BYTES);
    issue(PLEN'(MEM_BYTES) + a, SZ_BUS, SINGLE, 1'b1);
    issue(a, SZ_BUS, SINGLE, 1'b0);
    issue(PLEN'(MEM_BYTES - 2 * BYTES), SZ_BUS, INCR4, 1'b0);
    issue(PLEN'(MEM_BYTES - 3 * BYTES), SZ_BUS, INCR8, 1'b1);
    issue(PLEN'(MEM_BYTES - 4 * BYTES), SZ_BUS, INCR4, 1'b0);
    issue(PLEN'(2 * MEM_BYTES + BYTES), SZ_BUS, SINGLE, 1'b0);
    issue(a, SZ_BUS, SINGLE, 1'b0);
    for (int i = 0; i < 12; i++) begin  // mixed singles with the strobe held
      rng = xorshift32(rng);
      issue(rand_addr(MEM_BYTES, BYTES), SZ_BUS, SINGLE, rng[3]);
    end
    drain();
    repeat (4) @(posedge HCLK);
    if (wdq.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("%0d write data words never taken by the bus", wdq.size());
      stop_fail();
    end
  end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== vlog.f ====
biu_ahb_pkg.sv
biu2ahb.sv
ahb_sram_slave.sv
biu_ahb_top.sv
tb_clkgen.sv
tb_biu_ahb.sv
